// ==== Bender.yml ====
package:
  name: control_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/isaPkg.sv
      - verilog/ctrlPkg.sv
      - verilog/instrDecoder.sv
      - verilog/stepSequencer.sv
      - verilog/controlWordEncoder.sv
      - verilog/controlUnit.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/controlUnitTb.sv

// ==== include/control_config.svh ====
`ifndef CONTROL_CONFIG_SVH
`define CONTROL_CONFIG_SVH

// Instruction field widths
`define CU_OPCODE_W 6
`define CU_FUNCT_W 6

// Wide enough for the longest counted phase
`define CU_STEP_W 6

// Memory wait cycles before the instruction register is loaded
`define CU_FETCH_WAIT_STEPS 3

// Busy cycles of the multiplier/divider before Hi and Lo are loaded
`define CU_MULDIV_STEPS 33

`endif

// ==== sources.f ====
+incdir+include
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/instrDecoder.sv
verilog/stepSequencer.sv
verilog/controlWordEncoder.sv
verilog/controlUnit.sv
verif/controlUnitTb.sv

// ==== verif/controlUnitTb.sv ====
`default_nettype none

`include "control_config.svh"

module controlUnitTb;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int ClkPeriod   = 40;
    localparam int DriveDelay  = 2;
    localparam int ResetCycles = 4;
    localparam int ProgLen     = 40;
    localparam int NumChoices  = 15;
    localparam int HaltChecks  = 10;
    localparam int FetchLen    = `CU_FETCH_WAIT_STEPS + 3;   // Wait, latch, decode, dispatch
    localparam int CycleLimit  = ProgLen * 40 + 100;       // Longest instruction is 40 cycles

    logic                    clk;
    logic                    reset;
    logic [`CU_OPCODE_W-1:0] opcode;
    logic [`CU_FUNCT_W-1:0]  funct;
    logic                    pcWrite;
    logic                    pcWriteCond;
    logic                    irWrite;
    logic                    regWrite;
    logic                    loadA;
    logic                    loadB;
    logic                    aluSrcA;
    logic                    loadAluOut;
    logic                    multDiv;
    logic                    loadHi;
    logic                    loadLo;
    logic                    loadDiv;
    logic                    rstOut;
    ctrlPkg::regDst_e        regDst;
    ctrlPkg::aluSrcB_e       aluSrcB;
    ctrlPkg::condSel_e       condControl;
    ctrlPkg::aluOp_e         aluOp;
    ctrlPkg::pcSource_e      pcSource;
    ctrlPkg::memToReg_e      memToReg;
    ctrlPkg::ctrlWord_t      seenWord;

    // Expected position of the DUT in the program
    isaPkg::instrClass_e curClass;
    int                  curCycle;
    logic                checking;
    int                  cycleCount = 0;
    logic [15:0]         progQueue[$];   // {opcode, funct, class}

    controlUnit controlUnit_i (.*);

    always #(ClkPeriod / 2) clk = ~clk;

    assign seenWord = {pcWrite, pcWriteCond, irWrite, regWrite, loadA, loadB, aluSrcA,
                       loadAluOut, multDiv, loadHi, loadLo, loadDiv, rstOut, regDst,
                       aluSrcB, condControl, aluOp, pcSource, memToReg};

    // Controls for cycle idx of an instruction counted from fetch
    function automatic ctrlPkg::ctrlWord_t expectWord(isaPkg::instrClass_e cls, int idx);
        ctrlPkg::ctrlWord_t w;
        int                 ex;
        logic               isAddi;
        w      = '0;
        ex     = idx - FetchLen;
        isAddi = (cls == isaPkg::ClsAddi);
        if (idx <= `CU_FETCH_WAIT_STEPS) begin
            w.aluSrcB = ctrlPkg::SrcBFour;
            w.aluOp   = ctrlPkg::AluAdd;
            w.pcWrite = (idx == `CU_FETCH_WAIT_STEPS);   // Latch cycle
            w.irWrite = (idx == `CU_FETCH_WAIT_STEPS);
        end else if (idx == FetchLen - 2) begin
            w.loadA      = 1'b1;
            w.loadB      = 1'b1;
            w.loadAluOut = 1'b1;
            w.aluSrcB    = ctrlPkg::SrcBOffset;
            w.aluOp      = ctrlPkg::AluAdd;
        end else if (idx >= FetchLen) begin
            case (cls)
                isaPkg::ClsAdd, isaPkg::ClsSub, isaPkg::ClsAnd, isaPkg::ClsAddi: begin
                    w.aluSrcA    = 1'b1;
                    w.loadAluOut = 1'b1;
                    w.regWrite   = (ex == 1);
                    w.aluOp      = (cls == isaPkg::ClsSub) ? ctrlPkg::AluSub :
                                   (cls == isaPkg::ClsAnd) ? ctrlPkg::AluAnd : ctrlPkg::AluAdd;
                    w.aluSrcB    = isAddi ? ctrlPkg::SrcBImm : ctrlPkg::SrcBReg;
                    w.regDst     = isAddi ? ctrlPkg::DstRt : ctrlPkg::DstRd;
                end
                isaPkg::ClsMult, isaPkg::ClsDiv: begin
                    w.multDiv = (cls == isaPkg::ClsMult);
                    if (ex < `CU_MULDIV_STEPS) begin
                        w.loadDiv = (cls == isaPkg::ClsDiv);
                    end else begin
                        w.loadHi = 1'b1;
                        w.loadLo = 1'b1;
                    end
                end
                isaPkg::ClsMfhi, isaPkg::ClsMflo: begin
                    w.regDst   = ctrlPkg::DstRd;
                    w.memToReg = (cls == isaPkg::ClsMfhi) ? ctrlPkg::WbHi : ctrlPkg::WbLo;
                    w.regWrite = (ex == 1);
                end
                isaPkg::ClsBeq, isaPkg::ClsBne, isaPkg::ClsBle, isaPkg::ClsBgt: begin
                    w.pcWriteCond = 1'b1;
                    w.aluSrcA     = 1'b1;
                    w.aluOp       = ctrlPkg::AluCompare;
                    w.pcSource    = ctrlPkg::PcBranchTarget;
                    w.condControl = (cls == isaPkg::ClsBeq) ? ctrlPkg::CondEq :
                                    (cls == isaPkg::ClsBle) ? ctrlPkg::CondLe :
                                    (cls == isaPkg::ClsBgt) ? ctrlPkg::CondGt : ctrlPkg::CondNe;
                end
                isaPkg::ClsResetOp: w.rstOut = 1'b1;
                default: w = '0;   // Halt
            endcase
        end
        return w;
    endfunction

    function automatic int instrLength(isaPkg::instrClass_e cls);
        case (cls)
            isaPkg::ClsMult, isaPkg::ClsDiv: return FetchLen + `CU_MULDIV_STEPS + 1;
            isaPkg::ClsAdd, isaPkg::ClsSub, isaPkg::ClsAnd, isaPkg::ClsAddi: return FetchLen + 2;
            isaPkg::ClsMfhi, isaPkg::ClsMflo: return FetchLen + 2;
            isaPkg::ClsNone: return FetchLen;
            isaPkg::ClsBreak: return FetchLen + HaltChecks + 1;   // Run ends before this
            default: return FetchLen + 1;   // Branches and reset pulse
        endcase
    endfunction

    // Instruction mix as {opcode, funct, class}
    function automatic logic [15:0] choiceWord(int sel);
        case (sel)
            0:  return {6'h00, 6'h20, isaPkg::ClsAdd};
            1:  return {6'h00, 6'h22, isaPkg::ClsSub};
            2:  return {6'h00, 6'h24, isaPkg::ClsAnd};
            3:  return {6'h08, 6'h15, isaPkg::ClsAddi};
            4:  return {6'h00, 6'h18, isaPkg::ClsMult};
            5:  return {6'h00, 6'h1A, isaPkg::ClsDiv};
            6:  return {6'h00, 6'h10, isaPkg::ClsMfhi};
            7:  return {6'h00, 6'h12, isaPkg::ClsMflo};
            8:  return {6'h04, 6'h00, isaPkg::ClsBeq};
            9:  return {6'h05, 6'h00, isaPkg::ClsBne};
            10: return {6'h06, 6'h00, isaPkg::ClsBle};
            11: return {6'h07, 6'h00, isaPkg::ClsBgt};
            12: return {6'h3F, 6'h00, isaPkg::ClsResetOp};
            13: return {6'h23, 6'h00, isaPkg::ClsNone};   // Load word
            default: return {6'h00, 6'h00, isaPkg::ClsNone};   // Shift
        endcase
    endfunction

    function automatic logic [11:0] strobeBits(ctrlPkg::ctrlWord_t w);
        return {w.pcWrite, w.pcWriteCond, w.irWrite, w.regWrite, w.loadA, w.loadB,
                w.aluSrcA, w.loadAluOut, w.multDiv, w.loadHi, w.loadLo, w.loadDiv};
    endfunction

    task automatic reportMismatch(string field, logic [11:0] got, logic [11:0] want);
        $display("ERROR at %0t ns: %s is %0b, expected %0b (%s, cycle %0d)",
                 $time, field, got, want, curClass.name(), curCycle);
        $display("ERRORS FOUND");
        $fatal(1, "Control output mismatch");
    endtask

    task automatic checkControl(ctrlPkg::ctrlWord_t got, ctrlPkg::ctrlWord_t want);
        if (strobeBits(got) !== strobeBits(want))
            reportMismatch("pcWrite..loadDiv", strobeBits(got), strobeBits(want));
        else if (got.regDst !== want.regDst)
            reportMismatch("regDst", got.regDst, want.regDst);
        else if (got.aluSrcB !== want.aluSrcB)
            reportMismatch("aluSrcB", got.aluSrcB, want.aluSrcB);
        else if (got.condControl !== want.condControl)
            reportMismatch("condControl", got.condControl, want.condControl);
        else if (got.aluOp !== want.aluOp)
            reportMismatch("aluOp", got.aluOp, want.aluOp);
        else if (got.pcSource !== want.pcSource)
            reportMismatch("pcSource", got.pcSource, want.pcSource);
        else if (got.memToReg !== want.memToReg)
            reportMismatch("memToReg", got.memToReg, want.memToReg);
    endtask

    task automatic checkReset(logic got, logic want);
        if (got !== want)
            reportMismatch("rstOut", got, want);
    endtask

    always @(negedge clk) begin : compare
        ctrlPkg::ctrlWord_t want;
        if (checking) begin
            want = expectWord(curClass, curCycle);
            checkControl(seenWord, want);
            checkReset(rstOut, want.rstOut);
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: the program did not reach its halt within %0d cycles", CycleLimit);
            $display("ERRORS FOUND");
            $fatal(1, "Simulation timed out");
        end
    end

    initial begin
        logic [15:0] instr;
        int          sel;
        void'($urandom(32'h4d16));
        clk      = 1'b0;
        reset    = 1'b1;
        opcode   = '0;
        funct    = '0;
        checking = 1'b0;
        curClass = isaPkg::ClsResetOp;
        curCycle = FetchLen;   // Reset cycles look like the reset pulse
        for (int i = 0; i < ProgLen; i++) begin
            sel = (i < NumChoices) ? i : $urandom_range(NumChoices - 1);   // Each kind once first
            progQueue.push_back(choiceWord(sel));
        end
        progQueue.push_back({6'h00, 6'h0D, isaPkg::ClsBreak});
        repeat (ResetCycles) begin
            @(posedge clk);
            #DriveDelay;
            checking = 1'b1;
        end
        reset = 1'b0;
        while (!(curClass == isaPkg::ClsBreak && curCycle == FetchLen + HaltChecks - 1)) begin
            @(posedge clk);
            #DriveDelay;
            if (curCycle + 1 == instrLength(curClass)) begin
                instr    = progQueue.pop_front();
                opcode   = instr[15:10];
                funct    = instr[9:4];
                curClass = isaPkg::instrClass_e'(instr[3:0]);
                curCycle = 0;
            end else begin
                curCycle++;
            end
        end
        @(posedge clk);   // Last halt cycle compared
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/controlUnit.sv ====
`default_nettype none

`include "control_config.svh"

module controlUnit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`CU_OPCODE_W-1:0] opcode,
    input  logic [`CU_FUNCT_W-1:0]  funct,
    output logic                    pcWrite,
    output logic                    pcWriteCond,
    output logic                    irWrite,
    output logic                    regWrite,
    output logic                    loadA,
    output logic                    loadB,
    output logic                    aluSrcA,
    output logic                    loadAluOut,
    output logic                    multDiv,
    output logic                    loadHi,
    output logic                    loadLo,
    output logic                    loadDiv,
    output ctrlPkg::regDst_e        regDst,
    output ctrlPkg::aluSrcB_e       aluSrcB,
    output ctrlPkg::condSel_e       condControl,
    output ctrlPkg::aluOp_e         aluOp,
    output ctrlPkg::pcSource_e      pcSource,
    output ctrlPkg::memToReg_e      memToReg,
    output logic                    rstOut
);

    isaPkg::instrClass_e decodedClass;
    isaPkg::instrClass_e activeClass;
    ctrlPkg::ctrlPhase_e phase;
    ctrlPkg::ctrlWord_t  ctrlWord;

    instrDecoder decoder_i (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (decodedClass)
    );

    stepSequencer sequencer_i (
        .clk         (clk),
        .reset       (reset),
        .instrClass  (decodedClass),
        .phase       (phase),
        .activeClass (activeClass)
    );

    controlWordEncoder encoder_i (
        .phase       (phase),
        .activeClass (activeClass),
        .ctrlWord    (ctrlWord)
    );

    // Control word out to the datapath pins
    assign pcWrite     = ctrlWord.pcWrite;
    assign pcWriteCond = ctrlWord.pcWriteCond;
    assign irWrite     = ctrlWord.irWrite;
    assign regWrite    = ctrlWord.regWrite;
    assign loadA       = ctrlWord.loadA;
    assign loadB       = ctrlWord.loadB;
    assign aluSrcA     = ctrlWord.aluSrcA;
    assign loadAluOut  = ctrlWord.loadAluOut;
    assign multDiv     = ctrlWord.multDiv;
    assign loadHi      = ctrlWord.loadHi;
    assign loadLo      = ctrlWord.loadLo;
    assign loadDiv     = ctrlWord.loadDiv;
    assign regDst      = ctrlWord.regDst;
    assign aluSrcB     = ctrlWord.aluSrcB;
    assign condControl = ctrlWord.condControl;
    assign aluOp       = ctrlWord.aluOp;
    assign pcSource    = ctrlWord.pcSource;
    assign memToReg    = ctrlWord.memToReg;
    assign rstOut      = ctrlWord.rstOut;

endmodule

`default_nettype wire

// ==== verilog/controlWordEncoder.sv ====
`default_nettype none

`include "control_config.svh"

module controlWordEncoder (
    input  ctrlPkg::ctrlPhase_e phase,
    input  isaPkg::instrClass_e activeClass,
    output ctrlPkg::ctrlWord_t  ctrlWord
);

    always_comb begin
        ctrlWord = '0;
        case (phase)
            ctrlPkg::DatapathReset: begin
                ctrlWord.rstOut = 1'b1;
            end
            ctrlPkg::FetchWait, ctrlPkg::FetchLatch: begin
                ctrlWord.aluSrcB = ctrlPkg::SrcBFour;   // PC + 4
                ctrlWord.aluOp   = ctrlPkg::AluAdd;
                if (phase == ctrlPkg::FetchLatch) begin
                    ctrlWord.pcWrite = 1'b1;
                    ctrlWord.irWrite = 1'b1;
                end
            end
            ctrlPkg::Decode: begin
                // Read registers, precompute branch target
                ctrlWord.loadA      = 1'b1;
                ctrlWord.loadB      = 1'b1;
                ctrlWord.loadAluOut = 1'b1;
                ctrlWord.aluSrcB    = ctrlPkg::SrcBOffset;
                ctrlWord.aluOp      = ctrlPkg::AluAdd;
            end
            ctrlPkg::AluCompute, ctrlPkg::AluWrite: begin
                ctrlWord.aluSrcA    = 1'b1;
                ctrlWord.loadAluOut = 1'b1;
                ctrlWord.regWrite   = (phase == ctrlPkg::AluWrite);
                case (activeClass)
                    isaPkg::ClsSub: ctrlWord.aluOp = ctrlPkg::AluSub;
                    isaPkg::ClsAnd: ctrlWord.aluOp = ctrlPkg::AluAnd;
                    default:        ctrlWord.aluOp = ctrlPkg::AluAdd;
                endcase
                if (activeClass == isaPkg::ClsAddi) begin
                    ctrlWord.aluSrcB = ctrlPkg::SrcBImm;
                    ctrlWord.regDst  = ctrlPkg::DstRt;
                end else begin
                    ctrlWord.aluSrcB = ctrlPkg::SrcBReg;
                    ctrlWord.regDst  = ctrlPkg::DstRd;
                end
            end
            ctrlPkg::MulDivBusy: begin
                ctrlWord.multDiv = (activeClass == isaPkg::ClsMult);
                ctrlWord.loadDiv = (activeClass == isaPkg::ClsDiv);
            end
            ctrlPkg::MulDivDone: begin
                ctrlWord.loadHi  = 1'b1;
                ctrlWord.loadLo  = 1'b1;
                ctrlWord.multDiv = (activeClass == isaPkg::ClsMult);   // Keeps mult result selected
            end
            ctrlPkg::MoveSelect, ctrlPkg::MoveWrite: begin
                ctrlWord.regDst   = ctrlPkg::DstRd;
                ctrlWord.memToReg = (activeClass == isaPkg::ClsMfhi) ? ctrlPkg::WbHi
                                                                     : ctrlPkg::WbLo;
                ctrlWord.regWrite = (phase == ctrlPkg::MoveWrite);
            end
            ctrlPkg::BranchResolve: begin
                ctrlWord.pcWriteCond = 1'b1;
                ctrlWord.aluSrcA     = 1'b1;
                ctrlWord.aluOp       = ctrlPkg::AluCompare;
                ctrlWord.pcSource    = ctrlPkg::PcBranchTarget;
                case (activeClass)
                    isaPkg::ClsBeq: ctrlWord.condControl = ctrlPkg::CondEq;
                    isaPkg::ClsBle: ctrlWord.condControl = ctrlPkg::CondLe;
                    isaPkg::ClsBgt: ctrlWord.condControl = ctrlPkg::CondGt;
                    default:        ctrlWord.condControl = ctrlPkg::CondNe;
                endcase
            end
            default: begin
                ctrlWord = '0;   // Dispatch, Halt
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/ctrlPkg.sv ====
`default_nettype none

`include "control_config.svh"

package ctrlPkg;

    typedef enum logic [3:0] {
        DatapathReset,
        FetchWait,
        FetchLatch,
        Decode,
        Dispatch,
        AluCompute,
        AluWrite,
        MulDivBusy,
        MulDivDone,
        MoveSelect,
        MoveWrite,
        BranchResolve,
        Halt
    } ctrlPhase_e;

    typedef enum logic [2:0] {
        AluNop     = 3'd0,
        AluAdd     = 3'd1,
        AluSub     = 3'd2,
        AluAnd     = 3'd3,
        AluCompare = 3'd7
    } aluOp_e;

    typedef enum logic [1:0] {
        SrcBReg    = 2'd0,
        SrcBImm    = 2'd1,
        SrcBOffset = 2'd2,   // Shifted immediate for branch target
        SrcBFour   = 2'd3
    } aluSrcB_e;

    typedef enum logic [1:0] {
        DstRt = 2'd0,
        DstRd = 2'd1
    } regDst_e;

    typedef enum logic [1:0] {
        CondNe = 2'd0,
        CondEq = 2'd1,
        CondLe = 2'd2,
        CondGt = 2'd3
    } condSel_e;

    typedef enum logic [2:0] {
        PcAluResult    = 3'd0,
        PcBranchTarget = 3'd3   // AluOut holds target from decode
    } pcSource_e;

    typedef enum logic [2:0] {
        WbAluOut = 3'd0,
        WbHi     = 3'd2,
        WbLo     = 3'd3
    } memToReg_e;

    // Full set of datapath controls for one cycle
    typedef struct packed {
        logic       pcWrite;
        logic       pcWriteCond;
        logic       irWrite;
        logic       regWrite;
        logic       loadA;
        logic       loadB;
        logic       aluSrcA;
        logic       loadAluOut;
        logic       multDiv;
        logic       loadHi;
        logic       loadLo;
        logic       loadDiv;
        logic       rstOut;
        regDst_e    regDst;
        aluSrcB_e   aluSrcB;
        condSel_e   condControl;
        aluOp_e     aluOp;
        pcSource_e  pcSource;
        memToReg_e  memToReg;
    } ctrlWord_t;

endpackage

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
`default_nettype none

`include "control_config.svh"

module instrDecoder (
    input  logic [`CU_OPCODE_W-1:0] opcode,
    input  logic [`CU_FUNCT_W-1:0]  funct,
    output isaPkg::instrClass_e     instrClass
);

    isaPkg::instrClass_e rtypeClass;

    // R-type split on funct
    always_comb begin
        case (funct)
            isaPkg::ADD:   rtypeClass = isaPkg::ClsAdd;
            isaPkg::SUB:   rtypeClass = isaPkg::ClsSub;
            isaPkg::AND:   rtypeClass = isaPkg::ClsAnd;
            isaPkg::MULT:  rtypeClass = isaPkg::ClsMult;
            isaPkg::DIV:   rtypeClass = isaPkg::ClsDiv;
            isaPkg::MFHI:  rtypeClass = isaPkg::ClsMfhi;
            isaPkg::MFLO:  rtypeClass = isaPkg::ClsMflo;
            isaPkg::BREAK: rtypeClass = isaPkg::ClsBreak;
            default:       rtypeClass = isaPkg::ClsNone;   // Shifts, SLT, JR etc.
        endcase
    end

    always_comb begin
        case (opcode)
            isaPkg::RTYPE: begin
                instrClass = rtypeClass;
            end
            isaPkg::ADDI: begin
                instrClass = isaPkg::ClsAddi;
            end
            isaPkg::BEQ: begin
                instrClass = isaPkg::ClsBeq;
            end
            isaPkg::BNE: begin
                instrClass = isaPkg::ClsBne;
            end
            isaPkg::BLE: begin
                instrClass = isaPkg::ClsBle;
            end
            isaPkg::BGT: begin
                instrClass = isaPkg::ClsBgt;
            end
            isaPkg::RESETOP: begin
                instrClass = isaPkg::ClsResetOp;
            end
            default: begin
                instrClass = isaPkg::ClsNone;   // Loads, stores, jumps
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/isaPkg.sv ====
`default_nettype none

`include "control_config.svh"

package isaPkg;

    // Primary opcodes handled by the unit
    typedef enum logic [`CU_OPCODE_W-1:0] {
        RTYPE   = 6'h00,
        BEQ     = 6'h04,
        BNE     = 6'h05,
        BLE     = 6'h06,
        BGT     = 6'h07,
        ADDI    = 6'h08,
        RESETOP = 6'h3F   // Reserved, pulses datapath reset
    } opcode_e;

    // Funct field of R-type instructions
    typedef enum logic [`CU_FUNCT_W-1:0] {
        BREAK = 6'h0D,
        MFHI  = 6'h10,
        MFLO  = 6'h12,
        MULT  = 6'h18,
        DIV   = 6'h1A,
        ADD   = 6'h20,
        SUB   = 6'h22,
        AND   = 6'h24
    } funct_e;

    // One entry per execute sequence
    typedef enum logic [3:0] {
        ClsAdd,
        ClsSub,
        ClsAnd,
        ClsAddi,
        ClsMult,
        ClsDiv,
        ClsMfhi,
        ClsMflo,
        ClsBeq,
        ClsBne,
        ClsBle,
        ClsBgt,
        ClsBreak,
        ClsResetOp,
        ClsNone      // Unsupported, back to fetch
    } instrClass_e;

endpackage

`default_nettype wire

// ==== verilog/stepSequencer.sv ====
`default_nettype none

`include "control_config.svh"

module stepSequencer (
    input  logic                clk,
    input  logic                reset,
    input  isaPkg::instrClass_e instrClass,
    output ctrlPkg::ctrlPhase_e phase,
    output isaPkg::instrClass_e activeClass
);

    logic [`CU_STEP_W-1:0] step;
    logic [`CU_STEP_W-1:0] stepLimit;
    logic                  counting;
    logic                  stepDone;
    ctrlPkg::ctrlPhase_e   nextPhase;

    // Only the fetch wait and the mult/div busy phases last more than one cycle
    always_comb begin
        case (phase)
            ctrlPkg::FetchWait: begin
                counting  = 1'b1;
                stepLimit = `CU_STEP_W'(`CU_FETCH_WAIT_STEPS - 1);
            end
            ctrlPkg::MulDivBusy: begin
                counting  = 1'b1;
                stepLimit = `CU_STEP_W'(`CU_MULDIV_STEPS - 1);
            end
            default: begin
                counting  = 1'b0;
                stepLimit = '0;
            end
        endcase
    end

    assign stepDone = (step == stepLimit);

    always_comb begin
        case (phase)
            ctrlPkg::DatapathReset: nextPhase = ctrlPkg::FetchWait;
            ctrlPkg::FetchWait:     nextPhase = stepDone ? ctrlPkg::FetchLatch : ctrlPkg::FetchWait;
            ctrlPkg::FetchLatch:    nextPhase = ctrlPkg::Decode;
            ctrlPkg::Decode:        nextPhase = ctrlPkg::Dispatch;
            ctrlPkg::Dispatch: begin
                case (instrClass)
                    isaPkg::ClsAdd, isaPkg::ClsSub, isaPkg::ClsAnd, isaPkg::ClsAddi: begin
                        nextPhase = ctrlPkg::AluCompute;
                    end
                    isaPkg::ClsMult, isaPkg::ClsDiv: begin
                        nextPhase = ctrlPkg::MulDivBusy;
                    end
                    isaPkg::ClsMfhi, isaPkg::ClsMflo: begin
                        nextPhase = ctrlPkg::MoveSelect;
                    end
                    isaPkg::ClsBeq, isaPkg::ClsBne, isaPkg::ClsBle, isaPkg::ClsBgt: begin
                        nextPhase = ctrlPkg::BranchResolve;
                    end
                    isaPkg::ClsBreak: begin
                        nextPhase = ctrlPkg::Halt;
                    end
                    isaPkg::ClsResetOp: begin
                        nextPhase = ctrlPkg::DatapathReset;   // One cycle pulse
                    end
                    default: begin
                        nextPhase = ctrlPkg::FetchWait;   // Unsupported instruction
                    end
                endcase
            end
            ctrlPkg::AluCompute:    nextPhase = ctrlPkg::AluWrite;
            ctrlPkg::MulDivBusy:    nextPhase = stepDone ? ctrlPkg::MulDivDone : ctrlPkg::MulDivBusy;
            ctrlPkg::MoveSelect:    nextPhase = ctrlPkg::MoveWrite;
            ctrlPkg::AluWrite,
            ctrlPkg::MulDivDone,
            ctrlPkg::MoveWrite,
            ctrlPkg::BranchResolve: nextPhase = ctrlPkg::FetchWait;
            ctrlPkg::Halt:          nextPhase = ctrlPkg::Halt;   // Left only by reset
            default:                nextPhase = ctrlPkg::DatapathReset;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase       <= ctrlPkg::DatapathReset;
            step        <= '0;
            activeClass <= isaPkg::ClsNone;
        end else begin
            phase <= nextPhase;
            if (counting && !stepDone) begin
                step <= step + 1'b1;
            end else begin
                step <= '0;
            end
            // Class is held for the whole execute sequence
            if (phase == ctrlPkg::Dispatch) begin
                activeClass <= instrClass;
            end
        end
    end

endmodule

`default_nettype wire
